/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = conv_input_stage_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Result: PASSED

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* axis_shift_buffer.sv */
`timescale 1ns/1ps

module axis_shift_buffer (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  cnn_pkg::conv_mode_e                 mode,
    input  logic [cnn_pkg::kernel_h_width-1:0]  cfg_kernel_h_1,
    input  logic [cnn_pkg::word_width-1:0]      s_tdata [cnn_pkg::in_words-1:0],
    input  logic                                s_tvalid,
    output logic                                s_tready,
    output logic [cnn_pkg::word_width-1:0]      m_tdata [cnn_pkg::conv_units-1:0],
    output logic                                m_tvalid,
    input  logic                                m_tready,
    output logic                                beat_fire,
    output logic                                beat_last_shift
);

    cnn_pkg::shift_state_e                     state_q;
    logic [cnn_pkg::kernel_h_width-1:0]        shift_cnt;
    logic [cnn_pkg::word_width-1:0]            col_buf [cnn_pkg::in_words-1:0];
    logic                                      s_fire;
    logic                                      last_window;
    logic [cnn_pkg::conv_units*cnn_pkg::word_width-1:0] m_tdata_flat;

    assign m_tvalid    = (state_q == cnn_pkg::st_shifting);
    assign last_window = (shift_cnt == cfg_kernel_h_1);

    assign beat_fire       = m_tvalid && m_tready;
    assign beat_last_shift = m_tvalid && last_window;  // valid while the beat is presented

    // take a new column when empty, or while the last window of the current one leaves
    assign s_tready = (mode != cnn_pkg::mode_idle) &&
                      ((state_q == cnn_pkg::st_empty) || (beat_fire && last_window));

    assign s_fire = s_tvalid && s_tready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= cnn_pkg::st_empty;
            shift_cnt <= '0;
        end else if (s_fire) begin
            state_q   <= cnn_pkg::st_shifting;  // first window is row 0 of the new column
            shift_cnt <= '0;
        end else if (beat_fire) begin
            if (last_window) begin
                state_q   <= cnn_pkg::st_empty;
                shift_cnt <= '0;
            end else begin
                shift_cnt <= shift_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (s_fire) begin
            for (int w = 0; w < cnn_pkg::in_words; w++) begin
                col_buf[w] <= s_tdata[w];
            end
        end
    end

    // Row window j covers words j to j + conv_units - 1 of the held column.
    // shift_cnt never exceeds kernel_h_max - 1, so the index stays inside col_buf.
    always_comb begin
        for (int i = 0; i < cnn_pkg::conv_units; i++) begin
            m_tdata[i] = col_buf[int'(shift_cnt) + i];
        end
    end

    always_comb begin
        for (int i = 0; i < cnn_pkg::conv_units; i++) begin
            m_tdata_flat[i*cnn_pkg::word_width +: cnn_pkg::word_width] = m_tdata[i];
        end
    end

    // a stalled beat keeps its valid and its payload until the consumer takes it
    a_hold_under_stall : assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata_flat))
    );

endmodule

/* cnn_pkg.sv */
package cnn_pkg;

    localparam int word_width     = 16;  // bits per data word
    localparam int conv_units     = 8;   // words in each output row window
    localparam int kernel_h_max   = 3;
    localparam int kernel_w_max   = 3;

    // one image column per input beat, with the extra rows a tall kernel needs
    localparam int in_words       = conv_units + kernel_h_max - 1;

    localparam int kernel_h_width = 2;   // holds kernel_h_1 and the shift count
    localparam int kernel_w_width = 2;
    localparam int cin_width      = 5;   // up to 32 input channels
    localparam int cols_width     = 10;  // up to 1024 image columns

    localparam int tuser_width    = 4;

    // sideband bits carried to the convolution units
    localparam int tuser_is_1x1       = 0;
    localparam int tuser_is_max       = 1;
    localparam int tuser_is_relu      = 2;
    localparam int tuser_is_cols_1_k2 = 3;  // column where the kernel reaches the right edge

    typedef enum logic [1:0] {
        mode_idle,
        mode_conv,
        mode_1x1
    } conv_mode_e;

    typedef enum logic {
        st_empty,
        st_shifting
    } shift_state_e;

endpackage

/* conv_cfg_decode.sv */
`timescale 1ns/1ps

module conv_cfg_decode (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  logic                                start,
    input  logic                                frame_done,
    input  logic                                is_max,
    input  logic                                is_relu,
    input  logic [cnn_pkg::kernel_h_width-1:0]  kernel_h_1,
    input  logic [cnn_pkg::kernel_w_width-1:0]  kernel_w_1,
    input  logic [cnn_pkg::cin_width-1:0]       cin_1,
    input  logic [cnn_pkg::cols_width-1:0]      cols_1,
    output cnn_pkg::conv_mode_e                 mode,
    output logic [cnn_pkg::kernel_h_width-1:0]  cfg_kernel_h_1,
    output logic [cnn_pkg::kernel_w_width-1:0]  cfg_kernel_w_1,
    output logic [cnn_pkg::cin_width-1:0]       cfg_cin_1,
    output logic [cnn_pkg::cols_width-1:0]      cfg_cols_1,
    output logic                                cfg_is_max,
    output logic                                cfg_is_relu,
    output logic                                cfg_error
);

    logic                cfg_bad;
    cnn_pkg::conv_mode_e mode_next;

    assign cfg_bad = (kernel_h_1 >= cnn_pkg::kernel_h_max) ||
                     (kernel_w_1 >= cnn_pkg::kernel_w_max);

    always_comb begin
        if (cfg_bad) begin
            mode_next = cnn_pkg::mode_idle;  // an illegal kernel never starts a frame
        end else if (kernel_h_1 == '0 && kernel_w_1 == '0) begin
            mode_next = cnn_pkg::mode_1x1;
        end else begin
            mode_next = cnn_pkg::mode_conv;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mode           <= cnn_pkg::mode_idle;
            cfg_kernel_h_1 <= '0;
            cfg_kernel_w_1 <= '0;
            cfg_cin_1      <= '0;
            cfg_cols_1     <= '0;
            cfg_is_max     <= 1'b0;
            cfg_is_relu    <= 1'b0;
            cfg_error      <= 1'b0;
        end else if (start) begin
            mode           <= mode_next;
            cfg_kernel_h_1 <= kernel_h_1;
            cfg_kernel_w_1 <= kernel_w_1;
            cfg_cin_1      <= cin_1;
            cfg_cols_1     <= cols_1;
            cfg_is_max     <= is_max;
            cfg_is_relu    <= is_relu;
            cfg_error      <= cfg_bad;  // held until the next start
        end else if (frame_done) begin
            mode           <= cnn_pkg::mode_idle;
        end
    end

    // a new layer may only be loaded once the previous frame has drained
    a_start_when_idle : assert property (
        @(posedge aclk) disable iff (!arst_n)
        start |-> mode == cnn_pkg::mode_idle
    );

endmodule

/* conv_input_stage.sv */
`timescale 1ns/1ps

module conv_input_stage (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  logic                                start,
    input  logic [cnn_pkg::kernel_h_width-1:0]  kernel_h_1,
    input  logic [cnn_pkg::kernel_w_width-1:0]  kernel_w_1,
    input  logic [cnn_pkg::cin_width-1:0]       cin_1,
    input  logic [cnn_pkg::cols_width-1:0]      cols_1,
    input  logic                                is_max,
    input  logic                                is_relu,
    input  logic [cnn_pkg::word_width-1:0]      s_tdata [cnn_pkg::in_words-1:0],
    input  logic                                s_tvalid,
    output logic                                s_tready,
    output logic [cnn_pkg::word_width-1:0]      m_tdata [cnn_pkg::conv_units-1:0],
    output logic                                m_tvalid,
    input  logic                                m_tready,
    output logic                                m_tlast,
    output logic [cnn_pkg::tuser_width-1:0]     m_tuser,
    output logic                                cfg_error
);

    cnn_pkg::conv_mode_e                mode;
    logic [cnn_pkg::kernel_h_width-1:0] cfg_kernel_h_1;
    logic [cnn_pkg::kernel_w_width-1:0] cfg_kernel_w_1;
    logic [cnn_pkg::cin_width-1:0]      cfg_cin_1;
    logic [cnn_pkg::cols_width-1:0]     cfg_cols_1;
    logic                               cfg_is_max;
    logic                               cfg_is_relu;
    logic                               beat_fire;
    logic                               beat_last_shift;
    logic                               frame_done;

    conv_cfg_decode conv_cfg_decode_inst (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .start          (start),
        .frame_done     (frame_done),
        .is_max         (is_max),
        .is_relu        (is_relu),
        .kernel_h_1     (kernel_h_1),
        .kernel_w_1     (kernel_w_1),
        .cin_1          (cin_1),
        .cols_1         (cols_1),
        .mode           (mode),
        .cfg_kernel_h_1 (cfg_kernel_h_1),
        .cfg_kernel_w_1 (cfg_kernel_w_1),
        .cfg_cin_1      (cfg_cin_1),
        .cfg_cols_1     (cfg_cols_1),
        .cfg_is_max     (cfg_is_max),
        .cfg_is_relu    (cfg_is_relu),
        .cfg_error      (cfg_error)
    );

    axis_shift_buffer axis_shift_buffer_inst (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .mode            (mode),
        .cfg_kernel_h_1  (cfg_kernel_h_1),
        .s_tdata         (s_tdata),
        .s_tvalid        (s_tvalid),
        .s_tready        (s_tready),
        .m_tdata         (m_tdata),
        .m_tvalid        (m_tvalid),
        .m_tready        (m_tready),
        .beat_fire       (beat_fire),
        .beat_last_shift (beat_last_shift)
    );

    conv_tuser_gen conv_tuser_gen_inst (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .mode            (mode),
        .beat_fire       (beat_fire),
        .beat_last_shift (beat_last_shift),
        .cfg_kernel_w_1  (cfg_kernel_w_1),
        .cfg_cin_1       (cfg_cin_1),
        .cfg_cols_1      (cfg_cols_1),
        .cfg_is_max      (cfg_is_max),
        .cfg_is_relu     (cfg_is_relu),
        .m_tuser         (m_tuser),
        .m_tlast         (m_tlast),
        .frame_done      (frame_done)
    );

endmodule

/* conv_input_stage_tb.sv */
`timescale 1ns/1ps

module conv_input_stage_tb;

    typedef logic [cnn_pkg::word_width-1:0] word_t;

    typedef struct packed {
        logic [cnn_pkg::conv_units*cnn_pkg::word_width-1:0] data;
        logic [cnn_pkg::tuser_width-1:0]                    user;
        logic                                               last;
    } expect_t;

    function automatic int frame_beats(input int kh, input int cin, input int cols);
        return (kh + 1) * (cin + 1) * (cols + 1);
    endfunction

    // sum of the legal frames below as the rejected one produces nothing
    localparam int total_beats = frame_beats(2, 5, 9) + frame_beats(0, 2, 3) +
                                 frame_beats(1, 3, 4) + frame_beats(2, 1, 5) +
                                 frame_beats(2, 0, 2);
    localparam int watchdog_cycles = 40 * total_beats + 200;

    logic                               aclk;
    logic                               arst_n;
    logic                               start;
    logic [cnn_pkg::kernel_h_width-1:0] kernel_h_1;
    logic [cnn_pkg::kernel_w_width-1:0] kernel_w_1;
    logic [cnn_pkg::cin_width-1:0]      cin_1;
    logic [cnn_pkg::cols_width-1:0]     cols_1;
    logic                               is_max;
    logic                               is_relu;
    word_t                              s_tdata [cnn_pkg::in_words-1:0];
    logic                               s_tvalid;
    logic                               s_tready;
    word_t                              m_tdata [cnn_pkg::conv_units-1:0];
    logic                               m_tvalid;
    logic                               m_tready;
    logic                               m_tlast;
    logic [cnn_pkg::tuser_width-1:0]    m_tuser;
    logic                               cfg_error;

    string       test_name;
    int          cur_kh;
    int          cur_kw;
    int          cur_cin;
    int          cur_cols;
    logic        cur_max;
    logic        cur_relu;
    int          n_rx;
    int          n_expected;
    logic        bp_on;
    logic [31:0] gap_seed;
    logic [31:0] ready_seed;

    tb_clock_gen tb_clock_gen_inst (
        .aclk   (aclk),
        .arst_n (arst_n)
    );

    conv_input_stage conv_input_stage_inst (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .start      (start),
        .kernel_h_1 (kernel_h_1),
        .kernel_w_1 (kernel_w_1),
        .cin_1      (cin_1),
        .cols_1     (cols_1),
        .is_max     (is_max),
        .is_relu    (is_relu),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .m_tdata    (m_tdata),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tlast    (m_tlast),
        .m_tuser    (m_tuser),
        .cfg_error  (cfg_error)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // output beat n comes from input beat n / (kh + 1) and row window n % (kh + 1)
    function automatic expect_t expected_beat(input int n, input int kh, input int kw,
                                              input int cin, input int cols,
                                              input logic mx, input logic rl);
        expect_t want;
        int      k;
        int      j;
        int      chan;
        int      col;
        k    = n / (kh + 1);
        j    = n % (kh + 1);
        chan = k % (cin + 1);  // input beats run channel first and column second
        col  = k / (cin + 1);
        for (int i = 0; i < cnn_pkg::conv_units; i++) begin
            want.data[i*cnn_pkg::word_width +: cnn_pkg::word_width] = word_t'((j + i) * 100 + k);
        end
        want.user                              = '0;
        want.user[cnn_pkg::tuser_is_1x1]       = (kh == 0 && kw == 0);
        want.user[cnn_pkg::tuser_is_max]       = mx;
        want.user[cnn_pkg::tuser_is_relu]      = rl;
        want.user[cnn_pkg::tuser_is_cols_1_k2] = (col == cols - kw / 2);
        want.last = (j == kh) && (chan == cin) && (col == cols);
        return want;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("[FAIL] %s %s beat %0d: expected %0h, actual %0h",
                 test_name, what, n_rx, expected, actual);
        $display("Result: FAILED");
        $fatal(1, "mismatch on %s", what);
    endtask

    task automatic report_problem(input string msg);
        $display("[FAIL] %s: %s", test_name, msg);
        $display("Result: FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic start_layer(input string name, input int kh, input int kw, input int cin,
                               input int cols, input logic mx, input logic rl);
        logic bad;
        bad        = (kh >= cnn_pkg::kernel_h_max) || (kw >= cnn_pkg::kernel_w_max);
        test_name  = name;
        cur_kh     = kh;
        cur_kw     = kw;
        cur_cin    = cin;
        cur_cols   = cols;
        cur_max    = mx;
        cur_relu   = rl;
        n_rx       = 0;
        n_expected = bad ? 0 : frame_beats(kh, cin, cols);
        kernel_h_1 = cnn_pkg::kernel_h_width'(kh);
        kernel_w_1 = cnn_pkg::kernel_w_width'(kw);
        cin_1      = cnn_pkg::cin_width'(cin);
        cols_1     = cnn_pkg::cols_width'(cols);
        is_max     = mx;
        is_relu    = rl;
        start      = 1'b1;
        @(posedge aclk);
        #1;
        start = 1'b0;
        assert (cfg_error == bad) else report_problem("cfg_error does not match the kernel size");
    endtask

    // holds one column on the slave port until the DUT takes it
    task automatic drive_column(input int k);
        logic took;
        for (int m = 0; m < cnn_pkg::in_words; m++) begin
            s_tdata[m] = word_t'(m * 100 + k);
        end
        s_tvalid = 1'b1;
        do begin
            @(negedge aclk);
            took = s_tready;
            @(posedge aclk);
            #1;
        end while (!took);
    endtask

    task automatic send_frame(input int n_in, input logic gaps);
        int idle;
        for (int k = 0; k < n_in; k++) begin
            if (gaps) begin
                gap_seed = lcg_next(gap_seed);
                idle     = int'(gap_seed[18:17]);
                s_tvalid = 1'b0;
                repeat (idle) begin
                    @(posedge aclk);
                    #1;
                end
            end
            drive_column(k);
        end
        s_tvalid = 1'b0;
    endtask

    task automatic wait_frame();
        while (n_rx < n_expected) begin
            @(posedge aclk);
            #1;
        end
        repeat (4) begin
            @(posedge aclk);
            #1;
        end
        assert (!m_tvalid && !s_tready) else report_problem("stage still busy after the frame");
    endtask

    task automatic run_frame(input string name, input int kh, input int kw, input int cin,
                             input int cols, input logic mx, input logic rl, input logic rnd);
        bp_on = rnd;
        start_layer(name, kh, kw, cin, cols, mx, rl);
        send_frame((cin + 1) * (cols + 1), rnd);
        wait_frame();
        bp_on = 1'b0;
    endtask

    // random back-pressure stalls about a quarter of the cycles
    initial begin
        m_tready = 1'b1;
        forever begin
            @(posedge aclk);
            if (bp_on) begin
                ready_seed = lcg_next(ready_seed);
                #1 m_tready = (ready_seed[17:16] != 2'b00);
            end else begin
                #1 m_tready = 1'b1;
            end
        end
    end

    // a beat seen at the falling edge transfers on the next rising edge
    always @(negedge aclk) begin : monitor
        expect_t                                            want;
        logic [cnn_pkg::conv_units*cnn_pkg::word_width-1:0] act_data;
        if (arst_n && m_tvalid && m_tready) begin
            assert (n_rx < n_expected) else report_problem("output beat arrived when none was due");
            want = expected_beat(n_rx, cur_kh, cur_kw, cur_cin, cur_cols, cur_max, cur_relu);
            for (int i = 0; i < cnn_pkg::conv_units; i++) begin
                act_data[i*cnn_pkg::word_width +: cnn_pkg::word_width] = m_tdata[i];
            end
            assert (act_data == want.data) else report_mismatch("tdata", want.data, act_data);
            assert (m_tuser == want.user)
                else report_mismatch("tuser", 128'(want.user), 128'(m_tuser));
            assert (m_tlast == want.last)
                else report_mismatch("tlast", 128'(want.last), 128'(m_tlast));
            n_rx = n_rx + 1;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge aclk);
        $display("Watchdog: %s did not finish in %0d cycles", test_name, watchdog_cycles);
        $display("Result: FAILED");
        $fatal(1, "simulation hung");
    end

    initial begin
        start      = 1'b0;
        kernel_h_1 = '0;
        kernel_w_1 = '0;
        cin_1      = '0;
        cols_1     = '0;
        is_max     = 1'b0;
        is_relu    = 1'b0;
        s_tvalid   = 1'b0;
        for (int m = 0; m < cnn_pkg::in_words; m++) begin
            s_tdata[m] = '0;
        end
        bp_on      = 1'b0;
        gap_seed   = 32'hc351;
        ready_seed = lcg_next(32'hc351);  // keeps the two random streams apart
        test_name  = "reset";
        n_rx       = 0;
        n_expected = 0;
        wait (arst_n);
        @(posedge aclk);
        #1;
        assert (!s_tready && !m_tvalid && !m_tlast && !cfg_error)
            else report_problem("outputs not idle after reset");

        run_frame("conv3x3", 2, 2, 5, 9, 1'b0, 1'b1, 1'b0);
        run_frame("conv1x1", 0, 0, 2, 3, 1'b1, 1'b0, 1'b0);
        run_frame("flags_random", 1, 2, 3, 4, 1'b1, 1'b1, 1'b1);
        run_frame("conv3x3_random", 2, 1, 1, 5, 1'b0, 1'b0, 1'b1);

        // kernel_h_1 of 3 is out of range so nothing may be accepted or produced
        start_layer("bad_kernel_h", 3, 1, 2, 2, 1'b0, 1'b0);
        drive_column_blocked();
        wait_frame();
        run_frame("after_error", 2, 0, 0, 2, 1'b1, 1'b0, 1'b1);

        $display("Result: PASSED");
        $finish;
    end

    task automatic drive_column_blocked();
        for (int m = 0; m < cnn_pkg::in_words; m++) begin
            s_tdata[m] = word_t'(m * 100);
        end
        s_tvalid = 1'b1;
        repeat (12) begin
            @(negedge aclk);
            assert (!s_tready) else report_problem("input accepted after a rejected configuration");
            @(posedge aclk);
            #1;
        end
        s_tvalid = 1'b0;
    endtask

endmodule

/* conv_tuser_gen.sv */
`timescale 1ns/1ps

module conv_tuser_gen (
    input  logic                                aclk,
    input  logic                                arst_n,
    input  cnn_pkg::conv_mode_e                 mode,
    input  logic                                beat_fire,
    input  logic                                beat_last_shift,
    input  logic [cnn_pkg::kernel_w_width-1:0]  cfg_kernel_w_1,
    input  logic [cnn_pkg::cin_width-1:0]       cfg_cin_1,
    input  logic [cnn_pkg::cols_width-1:0]      cfg_cols_1,
    input  logic                                cfg_is_max,
    input  logic                                cfg_is_relu,
    output logic [cnn_pkg::tuser_width-1:0]     m_tuser,
    output logic                                m_tlast,
    output logic                                frame_done
);

    logic [cnn_pkg::cin_width-1:0]  chan_cnt;
    logic [cnn_pkg::cols_width-1:0] col_cnt;
    logic [cnn_pkg::cols_width-1:0] col_k2;
    logic                           chan_wrap;
    logic                           col_wrap;
    logic                           column_done;

    assign chan_wrap   = (chan_cnt == cfg_cin_1);
    assign col_wrap    = (col_cnt == cfg_cols_1);
    assign column_done = beat_fire && beat_last_shift;  // every row window of one channel sent

    // the last column whose kernel footprint still fits the image
    assign col_k2 = cfg_cols_1 - cnn_pkg::cols_width'(cfg_kernel_w_1 >> 1);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            chan_cnt <= '0;
            col_cnt  <= '0;
        end else if (column_done) begin
            if (chan_wrap) begin
                chan_cnt <= '0;
                col_cnt  <= col_wrap ? '0 : col_cnt + 1'b1;  // wraps to zero at frame end
            end else begin
                chan_cnt <= chan_cnt + 1'b1;
            end
        end
    end

    assign m_tlast = beat_last_shift && chan_wrap && col_wrap;

    always_comb begin
        m_tuser                              = '0;
        m_tuser[cnn_pkg::tuser_is_1x1]       = (mode == cnn_pkg::mode_1x1);
        m_tuser[cnn_pkg::tuser_is_max]       = cfg_is_max;
        m_tuser[cnn_pkg::tuser_is_relu]      = cfg_is_relu;
        m_tuser[cnn_pkg::tuser_is_cols_1_k2] = (col_cnt == col_k2);
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= beat_fire && m_tlast;  // decode drops the mode on the next edge
        end
    end

    // output beats only exist inside a configured frame
    a_no_beat_when_idle : assert property (
        @(posedge aclk) disable iff (!arst_n)
        beat_fire |-> mode != cnn_pkg::mode_idle
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic arst_n
);

    localparam realtime half_period = 4ns;  // 8 ns clock

    initial begin
        aclk = 1'b0;
        forever #(half_period) aclk = ~aclk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge aclk);
        #1 arst_n = 1'b1;  // released on the same 1 ns offset as the stimulus
    end

endmodule

/* verilog.f */
cnn_pkg.sv
conv_cfg_decode.sv
axis_shift_buffer.sv
conv_tuser_gen.sv
conv_input_stage.sv
tb_clock_gen.sv
conv_input_stage_tb.sv
